//--- masked_conv.f
+incdir+verilog
verilog/masked_conv_pkg.sv
verilog/masked_full_adder.sv
verilog/masked_a2b_conv.sv
verilog/mask_rng.sv
verilog/masked_conv_regs.sv
verilog/masked_conv_top.sv
verif/masked_conv_tb.sv

//--- Makefile
# Verilator build and run for the masked A2B converter
TOP = masked_conv_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f masked_conv.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "^Test OK$$" run.log

clean:
	rm -rf obj_dir run.log

//--- verif/masked_conv_tb.sv
// ====================
// Table-driven testbench for masked_conv_top over AXI4-Lite.
// Completion is found by polling STATUS, every handshake wait is bounded.
// ====================
`timescale 1ns/1ps
`include "masked_conv_consts.svh"

module masked_conv_tb;

    localparam int N_ROWS   = 12;
    localparam int TIMEOUT  = 200;  // Cycles per handshake wait
    localparam int MAX_POLL = 50;   // STATUS reads before giving up

    typedef struct packed {
        masked_conv_pkg::word_t s0;
        masked_conv_pkg::word_t s1;
        masked_conv_pkg::word_t sum;  // (s0 + s1) mod 256
    } row_t;

    logic                      clk;
    logic                      rst_n;
    masked_conv_pkg::axi_req_t axi_req;
    masked_conv_pkg::axi_rsp_t axi_rsp;

    row_t        table_q [N_ROWS];
    int          n_checks;
    int          n_errors;
    int          err_mark;   // Error count at start of current test
    logic [31:0] lcg_state;

    masked_conv_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .axi_req_i (axi_req),
        .axi_rsp_o (axi_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // ==================== Helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic check_word(input string what, input masked_conv_pkg::word_t got,
                              input masked_conv_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error @%0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input string what, input masked_conv_pkg::axi_data_t got,
                              input masked_conv_pkg::axi_data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error @%0t: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input masked_conv_pkg::axi_resp_t got,
                              input masked_conv_pkg::axi_resp_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error @%0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic end_test(input string name);
        if (n_errors == err_mark) $display("%-28s pass", name);
        else $display("%-28s FAIL", name);
        err_mark = n_errors;
    endtask

    // ==================== AXI4-Lite master
    // Drive 1 ns after the edge, sample ready/valid at the falling edge
    task automatic axi_write(input masked_conv_pkg::axi_addr_t addr,
                             input masked_conv_pkg::axi_data_t data,
                             output masked_conv_pkg::axi_resp_t resp);
        int n;
        @(posedge clk);
        #1;
        axi_req.awvalid = 1'b1;
        axi_req.awaddr  = addr;
        axi_req.wvalid  = 1'b1;
        axi_req.wdata   = data;
        n = 0;
        @(negedge clk);
        while (!(axi_rsp.awready && axi_rsp.wready)) begin
            n++;
            if (n > TIMEOUT) give_up("write address and data ready");
            @(negedge clk);
        end
        @(posedge clk);  // Transfer edge
        #1;
        axi_req.awvalid = 1'b0;
        axi_req.wvalid  = 1'b0;
        axi_req.bready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!axi_rsp.bvalid) begin
            n++;
            if (n > TIMEOUT) give_up("write response");
            @(negedge clk);
        end
        resp = axi_rsp.bresp;
        @(posedge clk);
        #1;
        axi_req.bready = 1'b0;
    endtask

    task automatic axi_read(input masked_conv_pkg::axi_addr_t addr,
                            output masked_conv_pkg::axi_data_t data,
                            output masked_conv_pkg::axi_resp_t resp);
        int n;
        @(posedge clk);
        #1;
        axi_req.arvalid = 1'b1;
        axi_req.araddr  = addr;
        n = 0;
        @(negedge clk);
        while (!axi_rsp.arready) begin
            n++;
            if (n > TIMEOUT) give_up("read address ready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        axi_req.arvalid = 1'b0;
        axi_req.rready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!axi_rsp.rvalid) begin
            n++;
            if (n > TIMEOUT) give_up("read data");
            @(negedge clk);
        end
        data = axi_rsp.rdata;
        resp = axi_rsp.rresp;
        @(posedge clk);
        #1;
        axi_req.rready = 1'b0;
    endtask

    task automatic write_reg(input masked_conv_pkg::axi_addr_t addr,
                             input masked_conv_pkg::axi_data_t data);
        masked_conv_pkg::axi_resp_t resp;
        axi_write(addr, data, resp);
        check_resp("write response", resp, masked_conv_pkg::OKAY);
    endtask

    task automatic read_reg(input masked_conv_pkg::axi_addr_t addr,
                            output masked_conv_pkg::axi_data_t data);
        masked_conv_pkg::axi_resp_t resp;
        axi_read(addr, data, resp);
        check_resp("read response", resp, masked_conv_pkg::OKAY);
    endtask

    // Done set and nothing left in flight
    task automatic wait_done();
        masked_conv_pkg::axi_data_t st;
        int polls;
        polls = 0;
        read_reg(`MC_REG_STATUS, st);
        while (st[1:0] != 2'b10) begin
            polls++;
            if (polls > MAX_POLL) give_up("conversion done");
            read_reg(`MC_REG_STATUS, st);
        end
    endtask

    // Full conversion, returns RES0 ^ RES1
    task automatic convert(input masked_conv_pkg::word_t s0, input masked_conv_pkg::word_t s1,
                           output masked_conv_pkg::word_t xor_res);
        masked_conv_pkg::axi_data_t r0;
        masked_conv_pkg::axi_data_t r1;
        masked_conv_pkg::axi_data_t st;
        write_reg(`MC_REG_SHARE0, masked_conv_pkg::axi_data_t'(s0));
        write_reg(`MC_REG_SHARE1, masked_conv_pkg::axi_data_t'(s1));
        write_reg(`MC_REG_CTRL, 32'h1);  // Start
        read_reg(`MC_REG_STATUS, st);    // Busy set and old done cleared
        check_data("STATUS after start", st, 32'h1);
        wait_done();
        read_reg(`MC_REG_RES0, r0);
        read_reg(`MC_REG_RES1, r1);
        xor_res = masked_conv_pkg::word_t'(r0 ^ r1);
    endtask

    // ==================== Main sequence
    initial begin
        masked_conv_pkg::axi_data_t rd;
        masked_conv_pkg::axi_data_t st_before;
        masked_conv_pkg::axi_resp_t resp;
        masked_conv_pkg::word_t     res;
        rst_n     = 1'b0;
        axi_req   = '0;
        n_checks  = 0;
        n_errors  = 0;
        err_mark  = 0;
        table_q[0] = '{s0: 8'h00, s1: 8'h00, sum: 8'h00};
        table_q[1] = '{s0: 8'hFF, s1: 8'h01, sum: 8'h00};  // Carry out of the top bit
        table_q[2] = '{s0: 8'h80, s1: 8'h80, sum: 8'h00};
        table_q[3] = '{s0: 8'h7F, s1: 8'h7F, sum: 8'hFE};  // Long carry chain
        lcg_state = 32'h8cd5e537;
        for (int i = 4; i < N_ROWS; i++) begin
            lcg_state      = lcg_next(lcg_state);
            table_q[i].s0  = lcg_state[31:24];
            lcg_state      = lcg_next(lcg_state);
            table_q[i].s1  = lcg_state[31:24];
            table_q[i].sum = masked_conv_pkg::word_t'(table_q[i].s0 + table_q[i].s1);
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        read_reg(`MC_REG_STATUS, rd);
        check_data("STATUS after reset", rd, '0);
        read_reg(`MC_REG_RES0, rd);
        check_data("RES0 after reset", rd, '0);
        read_reg(`MC_REG_RES1, rd);
        check_data("RES1 after reset", rd, '0);
        end_test("reset values");

        for (int i = 0; i < N_ROWS; i++) begin
            convert(table_q[i].s0, table_q[i].s1, res);
            check_word($sformatf("row %0d result", i), res, table_q[i].sum);
            end_test($sformatf("row %0d %02h+%02h", i, table_q[i].s0, table_q[i].s1));
        end

        // Second start while the first is still in the pipeline
        write_reg(`MC_REG_SHARE0, 32'h3C);
        write_reg(`MC_REG_SHARE1, 32'h5A);
        write_reg(`MC_REG_CTRL, 32'h1);
        write_reg(`MC_REG_SHARE0, 32'hC3);
        write_reg(`MC_REG_CTRL, 32'h1);
        read_reg(`MC_REG_STATUS, rd);
        check_data("busy after second start", rd & 32'h1, 32'h1);
        wait_done();
        read_reg(`MC_REG_RES0, rd);
        read_reg(`MC_REG_RES1, st_before);
        check_word("back-to-back result", masked_conv_pkg::word_t'(rd ^ st_before),
                   masked_conv_pkg::word_t'(8'hC3 + 8'h5A));
        end_test("back-to-back starts");

        // Zeroize right behind a start kills the conversion
        write_reg(`MC_REG_SHARE0, 32'h11);
        write_reg(`MC_REG_SHARE1, 32'h22);
        write_reg(`MC_REG_CTRL, 32'h1);
        write_reg(`MC_REG_CTRL, 32'h2);
        for (int k = 0; k < 8; k++) begin  // Spans well over MC_LAT cycles
            read_reg(`MC_REG_STATUS, rd);
            check_data("done after zeroize", rd & 32'h2, '0);
        end
        read_reg(`MC_REG_RES0, rd);
        check_data("RES0 after zeroize", rd, '0);
        read_reg(`MC_REG_RES1, rd);
        check_data("RES1 after zeroize", rd, '0);
        convert(8'hA5, 8'h6E, res);
        check_word("result after zeroize", res, masked_conv_pkg::word_t'(8'hA5 + 8'h6E));
        end_test("zeroize");

        // Error responses
        axi_read(5'h18, rd, resp);
        check_resp("unmapped read response", resp, masked_conv_pkg::SLVERR);
        check_data("unmapped read data", rd, '0);
        read_reg(`MC_REG_STATUS, st_before);
        axi_write(`MC_REG_STATUS, 32'h3, resp);
        check_resp("STATUS write response", resp, masked_conv_pkg::SLVERR);
        read_reg(`MC_REG_STATUS, rd);
        check_data("STATUS after write", rd, st_before);
        end_test("error responses");

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/masked_conv_top.sv
// ====================
// Masked A2B converter behind an AXI4-Lite register block
// ====================
`timescale 1ns/1ps
`include "masked_conv_consts.svh"

module masked_conv_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  masked_conv_pkg::axi_req_t axi_req_i,
    output masked_conv_pkg::axi_rsp_t axi_rsp_o
);

    masked_conv_pkg::masked_word_t conv_in;   // Arithmetic shares to converter
    masked_conv_pkg::masked_word_t conv_out;  // Boolean shares back
    masked_conv_pkg::rnd_bundle_t  rnd;       // Fresh masks, every cycle
    logic                          zeroize;

    masked_conv_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .axi_req_i  (axi_req_i),
        .axi_rsp_o  (axi_rsp_o),
        .conv_in_o  (conv_in),
        .conv_out_i (conv_out),
        .zeroize_o  (zeroize)
    );

    mask_rng u_rng (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize_i (zeroize),
        .rnd_o     (rnd)
    );

    masked_a2b_conv #(
        .WIDTH (`MC_WIDTH)
    ) u_conv (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize_i (zeroize),
        .a_i       (conv_in),
        .rnd_i     (rnd),
        .b_o       (conv_out)
    );

endmodule

//--- verilog/masked_conv_regs.sv
// ====================
// AXI4-Lite slave, one outstanding read and one write.
// No wstrb, whole-word writes only; results tracked by a token shift register.
// ====================
`timescale 1ns/1ps
`include "masked_conv_consts.svh"

module masked_conv_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  masked_conv_pkg::axi_req_t     axi_req_i,
    output masked_conv_pkg::axi_rsp_t     axi_rsp_o,
    output masked_conv_pkg::masked_word_t conv_in_o,
    input  masked_conv_pkg::masked_word_t conv_out_i,
    output logic                          zeroize_o
);

    // ==================== Declarations
    logic                          wr_fire, rd_fire;    // Channel transfers
    logic                          wr_ok, rd_ok;        // Address decode result
    logic                          wr_ctrl, wr_start, wr_zero;
    logic                          bvalid_q, rvalid_q;
    masked_conv_pkg::axi_resp_t    bresp_q, rresp_q;
    masked_conv_pkg::axi_data_t    rd_data, rdata_q;
    masked_conv_pkg::word_t        share0_q, share1_q;
    masked_conv_pkg::word_t        res0_q, res1_q;
    masked_conv_pkg::masked_word_t conv_in_q;
    logic                          start_q, zeroize_q, done_q, busy;
    logic [`MC_LAT-1:0]            tok_q;               // One bit per in-flight stage

    // ==================== Write channel
    assign wr_fire  = axi_req_i.awvalid && axi_req_i.wvalid && !bvalid_q;
    assign wr_ctrl  = wr_fire && (axi_req_i.awaddr == `MC_REG_CTRL);
    assign wr_start = wr_ctrl && axi_req_i.wdata[0];
    assign wr_zero  = wr_ctrl && axi_req_i.wdata[1];
    assign wr_ok    = (axi_req_i.awaddr == `MC_REG_CTRL)   ||
                      (axi_req_i.awaddr == `MC_REG_SHARE0) ||
                      (axi_req_i.awaddr == `MC_REG_SHARE1);  // Status and results are read-only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            bresp_q  <= masked_conv_pkg::OKAY;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_ok ? masked_conv_pkg::OKAY : masked_conv_pkg::SLVERR;
        end else if (axi_req_i.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            share0_q <= '0;
            share1_q <= '0;
        end else if (wr_fire && (axi_req_i.awaddr == `MC_REG_SHARE0)) begin
            share0_q <= axi_req_i.wdata[`MC_WIDTH-1:0];
        end else if (wr_fire && (axi_req_i.awaddr == `MC_REG_SHARE1)) begin
            share1_q <= axi_req_i.wdata[`MC_WIDTH-1:0];
        end
    end

    // ==================== Read channel
    always_comb begin
        rd_data = '0;
        rd_ok   = 1'b1;
        case (axi_req_i.araddr)
            `MC_REG_CTRL:   rd_data = '0;  // Command bits self-clear
            `MC_REG_SHARE0: rd_data = masked_conv_pkg::axi_data_t'(share0_q);
            `MC_REG_SHARE1: rd_data = masked_conv_pkg::axi_data_t'(share1_q);
            `MC_REG_STATUS: rd_data = {{(`MC_DATA_W-2){1'b0}}, done_q, busy};
            `MC_REG_RES0:   rd_data = masked_conv_pkg::axi_data_t'(res0_q);
            `MC_REG_RES1:   rd_data = masked_conv_pkg::axi_data_t'(res1_q);
            default:        rd_ok   = 1'b0;  // Unmapped, data stays 0
        endcase
    end

    assign rd_fire = axi_req_i.arvalid && !rvalid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            rresp_q  <= masked_conv_pkg::OKAY;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
            rdata_q  <= rd_data;
            rresp_q  <= rd_ok ? masked_conv_pkg::OKAY : masked_conv_pkg::SLVERR;
        end else if (axi_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // ==================== Conversion control
    // Start latches the shares, converter samples them on the next edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q   <= 1'b0;
            zeroize_q <= 1'b0;
            conv_in_q <= '0;
        end else begin
            start_q   <= wr_start;
            zeroize_q <= wr_zero;   // One-cycle pulse
            if (wr_start) begin
                conv_in_q.share0 <= share0_q;
                conv_in_q.share1 <= share1_q;
            end
        end
    end

    // Token enters with the converter sample, leaves when its result is valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tok_q  <= '0;
            res0_q <= '0;
            res1_q <= '0;
            done_q <= 1'b0;
        end else if (zeroize_q) begin
            tok_q  <= '0;
            res0_q <= '0;
            res1_q <= '0;
            done_q <= 1'b0;
        end else begin
            tok_q <= {tok_q[`MC_LAT-2:0], start_q};
            if (tok_q[`MC_LAT-1]) begin
                res0_q <= conv_out_i.share0;
                res1_q <= conv_out_i.share1;
            end
            if (wr_start) begin
                done_q <= 1'b0;                // New launch hides the old result
            end else if (tok_q[`MC_LAT-1]) begin
                done_q <= 1'b1;
            end
        end
    end

    assign busy = start_q || (|tok_q);

    // ==================== Outputs
    assign axi_rsp_o.awready = wr_fire;
    assign axi_rsp_o.wready  = wr_fire;
    assign axi_rsp_o.bvalid  = bvalid_q;
    assign axi_rsp_o.bresp   = bresp_q;
    assign axi_rsp_o.arready = !rvalid_q;
    assign axi_rsp_o.rvalid  = rvalid_q;
    assign axi_rsp_o.rdata   = rdata_q;
    assign axi_rsp_o.rresp   = rresp_q;
    assign conv_in_o         = conv_in_q;
    assign zeroize_o         = zeroize_q;

endmodule

//--- verilog/mask_rng.sv
// ====================
// Deterministic 32-bit Galois LFSR mask source, fixed seed.
// Stand-in only, never use as real randomness.
// ====================
`timescale 1ns/1ps
`include "masked_conv_consts.svh"

module mask_rng (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         zeroize_i,  // Reseed
    output masked_conv_pkg::rnd_bundle_t rnd_o
);

    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;  // x^32+x^22+x^2+x+1
    localparam logic [4:0]  ROT_STEP  = 5'd7;           // Odd, visits every offset

    logic [31:0] lfsr_q;
    logic [4:0]  rot_q;     // Slice offset
    logic [63:0] lfsr_dbl;  // Doubled state for wrap-around slicing
    logic [23:0] slice;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= `MC_LFSR_SEED;
            rot_q  <= '0;
        end else if (zeroize_i) begin
            lfsr_q <= `MC_LFSR_SEED;
            rot_q  <= '0;
        end else begin
            lfsr_q <= {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_POLY : 32'h0);  // Right-shift Galois
            rot_q  <= rot_q + ROT_STEP;
        end
    end

    // Rotated window, so outputs are not plain shifts of each other
    assign lfsr_dbl = {lfsr_q, lfsr_q};
    assign slice    = lfsr_dbl[rot_q +: 24];

    assign rnd_o.rnd    = slice[7:0];
    assign rnd_o.rnd_b0 = slice[15:8];
    assign rnd_o.rnd_b1 = slice[23:16];

endmodule

//--- verilog/masked_a2b_conv.sv
// ====================
// Arithmetic to Boolean shares via a masked ripple-carry adder.
// Latency WIDTH+2, one new word per cycle, no valid tracking here.
// ====================
`timescale 1ns/1ps

module masked_a2b_conv #(
    parameter int WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize_i,
    input  masked_conv_pkg::masked_word_t a_i,    // Arithmetic shares
    input  masked_conv_pkg::rnd_bundle_t  rnd_i,  // Fresh every cycle
    output masked_conv_pkg::masked_word_t b_o     // Boolean shares
);

    masked_conv_pkg::share_bit_t carry   [WIDTH];  // Carry into bit i
    masked_conv_pkg::share_bit_t sum_out [WIDTH];  // Aligned sum pairs

    // Bit 0 carry is a fresh sharing of zero, the spare random bit masks it
    assign carry[0] = {rnd_i.rnd[WIDTH-1], rnd_i.rnd[WIDTH-1]};

    genvar g;
    for (g = 0; g < WIDTH; g++) begin : gen_bit
        masked_conv_pkg::share_bit_t [g:0]         x_dly;  // Share 0 operand, skewed by g
        masked_conv_pkg::share_bit_t [g:0]         y_dly;  // Share 1 operand, skewed by g
        masked_conv_pkg::share_bit_t               s_bit;  // Sum pair of this bit
        masked_conv_pkg::share_bit_t [WIDTH-1-g:0] s_dly;  // Deskew toward the output

        // Remask each arithmetic bit into a Boolean pair, then delay by g stages
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                x_dly <= '0;
                y_dly <= '0;
            end else if (zeroize_i) begin
                x_dly <= '0;
                y_dly <= '0;
            end else begin
                x_dly[0] <= {rnd_i.rnd_b0[g], a_i.share0[g] ^ rnd_i.rnd_b0[g]};
                y_dly[0] <= {rnd_i.rnd_b1[g], a_i.share1[g] ^ rnd_i.rnd_b1[g]};
                for (int j = 1; j <= g; j++) begin
                    x_dly[j] <= x_dly[j-1];
                    y_dly[j] <= y_dly[j-1];
                end
            end
        end

        if (g < WIDTH-1) begin : gen_fa
            masked_full_adder u_fa (
                .clk       (clk),
                .rst_n     (rst_n),
                .zeroize_i (zeroize_i),
                .x_i       (x_dly[g]),
                .y_i       (y_dly[g]),
                .c_i       (carry[g]),
                .rnd_i     (rnd_i.rnd[g]),
                .s_o       (s_bit),
                .c_o       (carry[g+1])   // Lines up with x_dly of the next bit
            );
        end else begin : gen_msb
            // Top bit has no carry out, a plain XOR is enough
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    s_bit <= '0;
                end else if (zeroize_i) begin
                    s_bit <= '0;
                end else begin
                    s_bit <= x_dly[g] ^ y_dly[g] ^ carry[g];
                end
            end
        end

        // Low bits finish early, hold them until the top bit is ready
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                s_dly <= '0;
            end else if (zeroize_i) begin
                s_dly <= '0;
            end else begin
                s_dly[0] <= s_bit;
                for (int j = 1; j <= WIDTH-1-g; j++) begin
                    s_dly[j] <= s_dly[j-1];
                end
            end
        end

        assign sum_out[g] = s_dly[WIDTH-1-g];
    end

    // Regroup per-bit pairs into two share words
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            b_o.share0[i] = sum_out[i][0];
            b_o.share1[i] = sum_out[i][1];
        end
    end

endmodule

//--- verilog/masked_full_adder.sv
// ====================
// First-order masked full adder, one cycle latency.
// rnd_i must be fresh every cycle or the AND leaks.
// ====================
`timescale 1ns/1ps

module masked_full_adder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        zeroize_i,
    input  masked_conv_pkg::share_bit_t x_i,
    input  masked_conv_pkg::share_bit_t y_i,
    input  masked_conv_pkg::share_bit_t c_i,
    input  logic                        rnd_i,
    output masked_conv_pkg::share_bit_t s_o,
    output masked_conv_pkg::share_bit_t c_o
);

    masked_conv_pkg::share_bit_t xc;    // x ^ c, share-wise
    masked_conv_pkg::share_bit_t yc;    // y ^ c, share-wise
    masked_conv_pkg::share_bit_t prod;  // Masked (x^c)&(y^c)
    masked_conv_pkg::share_bit_t s_q;
    masked_conv_pkg::share_bit_t c_q;

    // Carry is maj(x,y,c) = ((x^c) & (y^c)) ^ c, so only one AND is needed
    assign xc = x_i ^ c_i;
    assign yc = y_i ^ c_i;

    // Domain-oriented AND, cross-domain terms hidden by rnd_i
    assign prod[0] = (xc[0] & yc[0]) ^ ((xc[0] & yc[1]) ^ rnd_i);
    assign prod[1] = (xc[1] & yc[1]) ^ ((xc[1] & yc[0]) ^ rnd_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_q <= '0;
            c_q <= '0;
        end else if (zeroize_i) begin
            s_q <= '0;
            c_q <= '0;
        end else begin
            s_q <= x_i ^ y_i ^ c_i;  // Linear, stays share-wise
            c_q <= prod ^ c_i;
        end
    end

    assign s_o = s_q;
    assign c_o = c_q;

endmodule

//--- verilog/masked_conv_pkg.sv
// ====================
// Shared types; widths come from the consts header
// ====================
`include "masked_conv_consts.svh"

package masked_conv_pkg;

    typedef logic [`MC_WIDTH-1:0]  word_t;       // One data word
    typedef logic [1:0]            share_bit_t;  // Bit 0 share0, bit 1 share1
    typedef logic [`MC_ADDR_W-1:0] axi_addr_t;
    typedef logic [`MC_DATA_W-1:0] axi_data_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // Share pair, arithmetic on the way in, Boolean on the way out
    typedef struct packed {
        word_t share0;
        word_t share1;
    } masked_word_t;

    typedef struct packed {
        word_t rnd;      // Adder refresh bits
        word_t rnd_b0;   // Remask of share 0
        word_t rnd_b1;   // Remask of share 1
    } rnd_bundle_t;

    // Master to slave
    typedef struct packed {
        logic      awvalid;
        axi_addr_t awaddr;
        logic      wvalid;
        axi_data_t wdata;
        logic      bready;
        logic      arvalid;
        axi_addr_t araddr;
        logic      rready;
    } axi_req_t;

    // Slave to master
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        axi_resp_t bresp;
        logic      arready;
        logic      rvalid;
        axi_data_t rdata;
        axi_resp_t rresp;
    } axi_rsp_t;

endpackage

//--- verilog/masked_conv_consts.svh
// ====================
// Widths, register map, LFSR seed and converter latency.
// MC_LAT has to track the pipeline depth of masked_a2b_conv.
// ====================
`ifndef MASKED_CONV_CONSTS_SVH
`define MASKED_CONV_CONSTS_SVH

`define MC_WIDTH      8                 // Share width
`define MC_ADDR_W     5                 // AXI4-Lite address bits
`define MC_DATA_W     32                // AXI4-Lite data bits
`define MC_LAT        (`MC_WIDTH + 2)   // Converter input to output, in cycles
`define MC_LFSR_SEED  32'hACE1_2B57     // Not an entropy source

`define MC_REG_CTRL   5'h00             // W: bit 0 start, bit 1 zeroize
`define MC_REG_SHARE0 5'h04             // RW: arithmetic share 0
`define MC_REG_SHARE1 5'h08             // RW: arithmetic share 1
`define MC_REG_STATUS 5'h0C             // R: bit 0 busy, bit 1 done
`define MC_REG_RES0   5'h10             // R: Boolean share 0
`define MC_REG_RES1   5'h14             // R: Boolean share 1

`endif
